// ==== verilog/runner_params.svh ====
`ifndef RUNNER_PARAMS_SVH
`define RUNNER_PARAMS_SVH

// Screen and coordinate sizes
`define RUNNER_XSCREEN 320
`define RUNNER_YSCREEN 240
`define RUNNER_X_W 9
`define RUNNER_Y_W 8
`define RUNNER_COLOR_W 9

// Box geometry
`define RUNNER_PLAYER_X 52
`define RUNNER_GROUND_Y 109
`define RUNNER_PLAYER_W 8
`define RUNNER_PLAYER_H 16
`define RUNNER_OBST_W 8
`define RUNNER_OBST_H 8

// Jump physics, in rows per frame tick
`define RUNNER_JUMP_FORCE 10
`define RUNNER_GRAVITY 1
`define RUNNER_FRAME_DIV 1024
`define RUNNER_RESPAWN_SPAN 100

// Clock and serial line
`define RUNNER_CLK_HZ 10_000_000
`define RUNNER_BAUD 125_000

// 3:3:3 colors
`define RUNNER_PLAYER_COLOR 9'b000111000
`define RUNNER_OBST_COLOR 9'b111000000
`define RUNNER_BG_COLOR 9'b111111111

`endif

// ==== verilog/runner_pkg.sv ====
`include "runner_params.svh"

package runner_pkg;

	typedef logic [`RUNNER_X_W-1:0] xcoord_t;
	typedef logic [`RUNNER_Y_W-1:0] ycoord_t;
	typedef logic [`RUNNER_COLOR_W-1:0] color_t;
	typedef logic [15:0] score_t;
	typedef logic [7:0] uart_byte_t;

	// Top-left corner of a box
	typedef struct packed {
		xcoord_t x;
		ycoord_t y;
	} box_pos_t;

	// One pixel write on the frame buffer bus
	typedef struct packed {
		logic write;
		xcoord_t x;
		ycoord_t y;
		color_t color;
	} pixel_wr_t;

	typedef enum logic [1:0] {JUMP_RUNNING, JUMP_ASCENDING, JUMP_DESCENDING} jump_state_e;
	typedef enum logic [1:0] {DRAW_WAIT_TICK, DRAW_REQUEST, DRAW_ERASE, DRAW_DRAW} draw_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
	typedef enum logic [1:0] {GNT_IDLE, GNT_PLAYER, GNT_OBST} grant_state_e;

endpackage

// ==== verilog/uart_cmd_rx.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module uart_cmd_rx (
	input logic Clock,
	input logic rst_n,
	input logic uart_rx,
	output logic jump_pulse
);
	localparam int OS_DIV = `RUNNER_CLK_HZ / (`RUNNER_BAUD * 16);
	localparam int OS_CW = (OS_DIV > 1) ? $clog2(OS_DIV) : 1;

	logic [OS_CW-1:0] os_div_cnt;
	logic os_tick;
	logic rx_meta;
	logic rx_sync;
	runner_pkg::rx_state_e rx_state;
	logic [3:0] os_cnt;
	logic [2:0] bit_idx;
	runner_pkg::uart_byte_t shift_reg;
	runner_pkg::uart_byte_t rx_byte;
	logic rx_strobe;

	// 16x oversample tick
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			os_div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (os_div_cnt == OS_CW'(OS_DIV - 1)) begin
			os_div_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			os_div_cnt <= os_div_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	// Line idles high, so the synchronizer resets to one
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_state <= runner_pkg::RX_IDLE;
			os_cnt <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			if (os_tick) begin
				case (rx_state)
					runner_pkg::RX_IDLE: if (!rx_sync) begin
						rx_state <= runner_pkg::RX_START;
						os_cnt <= 4'd7;
					end
					// Recheck the start bit half a bit later
					runner_pkg::RX_START: if (os_cnt != 4'd0) begin
						os_cnt <= os_cnt - 1'b1;
					end else if (!rx_sync) begin
						rx_state <= runner_pkg::RX_DATA;
						os_cnt <= 4'd15;
						bit_idx <= '0;
					end else begin
						rx_state <= runner_pkg::RX_IDLE;
					end
					runner_pkg::RX_DATA: if (os_cnt != 4'd0) begin
						os_cnt <= os_cnt - 1'b1;
					end else begin
						shift_reg[bit_idx] <= rx_sync;
						os_cnt <= 4'd15;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							rx_state <= runner_pkg::RX_STOP;
					end
					runner_pkg::RX_STOP: if (os_cnt != 4'd0) begin
						os_cnt <= os_cnt - 1'b1;
					end else begin
						// Framing error drops the byte
						rx_byte <= shift_reg;
						rx_strobe <= rx_sync;
						rx_state <= runner_pkg::RX_IDLE;
					end
					default: rx_state <= runner_pkg::RX_IDLE;
				endcase
			end
		end
	end

	// Only "J" is a command here
	always_ff @(posedge Clock) begin
		if (!rst_n)
			jump_pulse <= 1'b0;
		else
			jump_pulse <= rx_strobe && (rx_byte == runner_pkg::uart_byte_t'("J"));
	end

endmodule

// ==== verilog/player_motion.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module player_motion (
	input logic Clock,
	input logic rst_n,
	input logic jump_pulse,
	input logic game_over,
	output logic frame_tick,
	output runner_pkg::box_pos_t player_pos
);
	localparam int FRAME_CW = $clog2(`RUNNER_FRAME_DIV);
	localparam logic signed [7:0] JUMP_V = -`RUNNER_JUMP_FORCE;
	localparam logic signed [7:0] GRAVITY = `RUNNER_GRAVITY;
	localparam logic signed [9:0] GROUND = `RUNNER_GROUND_Y;

	logic [FRAME_CW-1:0] frame_cnt;
	runner_pkg::jump_state_e jump_state;
	runner_pkg::ycoord_t pos_y;
	logic signed [7:0] vel;
	logic signed [7:0] vel_next;
	logic signed [9:0] next_y;

	// Slow tick that paces all motion and redraws
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			frame_cnt <= '0;
			frame_tick <= 1'b0;
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
			frame_tick <= (frame_cnt == FRAME_CW'(`RUNNER_FRAME_DIV - 1));
		end
	end

	// Negative speed moves the player up the screen
	assign vel_next = vel + GRAVITY;
	assign next_y = $signed({2'b00, pos_y}) + vel;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			jump_state <= runner_pkg::JUMP_RUNNING;
			pos_y <= runner_pkg::ycoord_t'(`RUNNER_GROUND_Y);
			vel <= '0;
		end else if (!game_over) begin
			if (jump_pulse && jump_state == runner_pkg::JUMP_RUNNING) begin
				jump_state <= runner_pkg::JUMP_ASCENDING;
				vel <= JUMP_V;
			end else if (frame_tick && jump_state != runner_pkg::JUMP_RUNNING) begin
				if (next_y >= GROUND) begin
					// Landed
					pos_y <= runner_pkg::ycoord_t'(`RUNNER_GROUND_Y);
					vel <= '0;
					jump_state <= runner_pkg::JUMP_RUNNING;
				end else begin
					pos_y <= next_y[`RUNNER_Y_W-1:0];
					vel <= vel_next;
					if (vel_next >= 0)
						jump_state <= runner_pkg::JUMP_DESCENDING;
				end
			end
		end
	end

	assign player_pos.x = runner_pkg::xcoord_t'(`RUNNER_PLAYER_X);
	assign player_pos.y = pos_y;

endmodule

// ==== verilog/obstacle_motion.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module obstacle_motion (
	input logic Clock,
	input logic rst_n,
	input logic frame_tick,
	input logic respawn,
	input logic game_over,
	output runner_pkg::box_pos_t obst_pos
);
	localparam runner_pkg::xcoord_t START_X = `RUNNER_XSCREEN - `RUNNER_OBST_W;
	// Bottom edge sits on the same row as the player's feet
	localparam runner_pkg::ycoord_t OBST_Y =
		`RUNNER_GROUND_Y + `RUNNER_PLAYER_H - `RUNNER_OBST_H;

	logic [15:0] lfsr;
	runner_pkg::xcoord_t pos_x;
	runner_pkg::xcoord_t rand_ofs;

	// Free running, so the offset depends on when the pass happens
	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= 16'hACE1;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
	end

	assign rand_ofs = runner_pkg::xcoord_t'(lfsr % `RUNNER_RESPAWN_SPAN);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			pos_x <= START_X;
		end else if (!game_over) begin
			if (respawn)
				pos_x <= START_X + rand_ofs;
			else if (frame_tick)
				pos_x <= (pos_x <= runner_pkg::xcoord_t'(1)) ? START_X : pos_x - 1'b1;
		end
	end

	assign obst_pos.x = pos_x;
	assign obst_pos.y = OBST_Y;

endmodule

// ==== verilog/box_drawer.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module box_drawer #(
	parameter int BOX_W = 8,
	parameter int BOX_H = 8,
	parameter runner_pkg::color_t BOX_COLOR = `RUNNER_PLAYER_COLOR
) (
	input logic Clock,
	input logic rst_n,
	input logic frame_tick,
	input runner_pkg::box_pos_t pos,
	input logic gnt,
	output logic req,
	output runner_pkg::pixel_wr_t wr
);
	localparam int CX_W = (BOX_W > 1) ? $clog2(BOX_W) : 1;
	localparam int CY_W = (BOX_H > 1) ? $clog2(BOX_H) : 1;

	runner_pkg::draw_state_e state;
	runner_pkg::box_pos_t cur_pos;
	runner_pkg::box_pos_t old_pos;
	runner_pkg::box_pos_t base;
	runner_pkg::xcoord_t px;
	runner_pkg::ycoord_t py;
	logic [CX_W-1:0] cx;
	logic [CY_W-1:0] cy;
	logic last_col;
	logic last_row;
	logic on_screen;

	// Erase pass walks the old corner, draw pass the new one
	always_comb begin
		base = (state == runner_pkg::DRAW_ERASE) ? old_pos : cur_pos;
		px = base.x + runner_pkg::xcoord_t'(cx);
		py = base.y + runner_pkg::ycoord_t'(cy);
		last_col = (cx == CX_W'(BOX_W - 1));
		last_row = (cy == CY_W'(BOX_H - 1));
		// A respawned obstacle can start past the right edge
		on_screen = (px < `RUNNER_XSCREEN) && (py < `RUNNER_YSCREEN);
	end

	assign req = (state != runner_pkg::DRAW_WAIT_TICK);

	always_ff @(posedge Clock) begin
		wr.x <= px;
		wr.y <= py;
		wr.color <= (state == runner_pkg::DRAW_ERASE) ? `RUNNER_BG_COLOR : BOX_COLOR;
		if (!rst_n) begin
			state <= runner_pkg::DRAW_WAIT_TICK;
			cur_pos <= '0;
			cx <= '0;
			cy <= '0;
			wr.write <= 1'b0;
		end else begin
			wr.write <= 1'b0;
			case (state)
				runner_pkg::DRAW_WAIT_TICK: if (frame_tick) begin
					old_pos <= cur_pos;
					cur_pos <= pos;
					state <= runner_pkg::DRAW_REQUEST;
				end
				runner_pkg::DRAW_REQUEST: if (gnt) begin
					cx <= '0;
					cy <= '0;
					state <= runner_pkg::DRAW_ERASE;
				end
				runner_pkg::DRAW_ERASE, runner_pkg::DRAW_DRAW: begin
					wr.write <= on_screen;
					if (last_col) begin
						cx <= '0;
						cy <= last_row ? '0 : cy + 1'b1;
					end else begin
						cx <= cx + 1'b1;
					end
					if (last_col && last_row)
						state <= (state == runner_pkg::DRAW_ERASE) ?
							runner_pkg::DRAW_DRAW : runner_pkg::DRAW_WAIT_TICK;
				end
				default: state <= runner_pkg::DRAW_WAIT_TICK;
			endcase
		end
	end

endmodule

// ==== verilog/pixel_arbiter.sv ====
`timescale 1ns/10ps

module pixel_arbiter (
	input logic Clock,
	input logic rst_n,
	input logic player_req,
	input logic obst_req,
	input runner_pkg::pixel_wr_t player_wr,
	input runner_pkg::pixel_wr_t obst_wr,
	output logic player_gnt,
	output logic obst_gnt,
	output runner_pkg::pixel_wr_t pixel
);
	runner_pkg::grant_state_e gnt_state;
	runner_pkg::grant_state_e gnt_next;

	// Player wins ties, a grant holds until its request drops
	always_comb begin
		gnt_next = runner_pkg::GNT_IDLE;
		case (gnt_state)
			runner_pkg::GNT_IDLE:
				if (player_req)
					gnt_next = runner_pkg::GNT_PLAYER;
				else if (obst_req)
					gnt_next = runner_pkg::GNT_OBST;
			runner_pkg::GNT_PLAYER:
				if (player_req)
					gnt_next = runner_pkg::GNT_PLAYER;
			runner_pkg::GNT_OBST:
				if (obst_req)
					gnt_next = runner_pkg::GNT_OBST;
			default: gnt_next = runner_pkg::GNT_IDLE;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rst_n)
			gnt_state <= runner_pkg::GNT_IDLE;
		else
			gnt_state <= gnt_next;
	end

	assign player_gnt = (gnt_state == runner_pkg::GNT_PLAYER);
	assign obst_gnt = (gnt_state == runner_pkg::GNT_OBST);
	assign pixel = player_gnt ? player_wr : (obst_gnt ? obst_wr : '0);

endmodule

// ==== verilog/score_keeper.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module score_keeper (
	input logic Clock,
	input logic rst_n,
	input runner_pkg::box_pos_t player_pos,
	input runner_pkg::box_pos_t obst_pos,
	output runner_pkg::score_t score,
	output logic game_over,
	output logic respawn
);
	// One spare bit so right and bottom edges never wrap
	localparam int XE = `RUNNER_X_W + 1;
	localparam int YE = `RUNNER_Y_W + 1;

	logic [XE-1:0] p_left;
	logic [XE-1:0] p_right;
	logic [XE-1:0] o_left;
	logic [XE-1:0] o_right;
	logic [YE-1:0] p_top;
	logic [YE-1:0] p_bottom;
	logic [YE-1:0] o_top;
	logic [YE-1:0] o_bottom;
	logic collision;
	logic prev_collision;
	runner_pkg::xcoord_t prev_obst_x;
	logic score_given;
	logic crossed;

	always_comb begin
		p_left = {1'b0, player_pos.x};
		p_right = p_left + XE'(`RUNNER_PLAYER_W);
		o_left = {1'b0, obst_pos.x};
		o_right = o_left + XE'(`RUNNER_OBST_W);
		p_top = {1'b0, player_pos.y};
		p_bottom = p_top + YE'(`RUNNER_PLAYER_H);
		o_top = {1'b0, obst_pos.y};
		o_bottom = o_top + YE'(`RUNNER_OBST_H);
		// Touching edges count as a hit
		collision = (p_right >= o_left) && (o_right >= p_left) &&
			(p_bottom >= o_top) && (o_bottom >= p_top);
		crossed = (prev_obst_x > player_pos.x) && (obst_pos.x <= player_pos.x);
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			score <= '0;
			game_over <= 1'b0;
			respawn <= 1'b0;
			prev_collision <= 1'b0;
			prev_obst_x <= '0;
			score_given <= 1'b0;
		end else begin
			prev_collision <= collision;
			prev_obst_x <= obst_pos.x;
			respawn <= 1'b0;
			if (collision)
				game_over <= 1'b1;
			if (!game_over) begin
				// x only ever grows on a wrap or a respawn
				if (obst_pos.x > prev_obst_x)
					score_given <= 1'b0;
				else if (crossed && !score_given && !collision && !prev_collision) begin
					score <= score + runner_pkg::score_t'(1);
					respawn <= 1'b1;
					score_given <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/runner_top.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module runner_top (
	input logic Clock,
	input logic rst_n,
	input logic uart_rx,
	output runner_pkg::pixel_wr_t pixel,
	output runner_pkg::score_t score,
	output logic game_over
);
	logic jump_pulse;
	logic frame_tick;
	logic respawn;
	runner_pkg::box_pos_t player_pos;
	runner_pkg::box_pos_t obst_pos;
	logic player_req;
	logic obst_req;
	logic player_gnt;
	logic obst_gnt;
	runner_pkg::pixel_wr_t player_wr;
	runner_pkg::pixel_wr_t obst_wr;

	uart_cmd_rx u_uart (
		.Clock(Clock),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.jump_pulse(jump_pulse)
	);

	player_motion u_player (
		.Clock(Clock),
		.rst_n(rst_n),
		.jump_pulse(jump_pulse),
		.game_over(game_over),
		.frame_tick(frame_tick),
		.player_pos(player_pos)
	);

	obstacle_motion u_obst (
		.Clock(Clock),
		.rst_n(rst_n),
		.frame_tick(frame_tick),
		.respawn(respawn),
		.game_over(game_over),
		.obst_pos(obst_pos)
	);

	box_drawer #(
		.BOX_W(`RUNNER_PLAYER_W),
		.BOX_H(`RUNNER_PLAYER_H),
		.BOX_COLOR(`RUNNER_PLAYER_COLOR)
	) u_player_draw (
		.Clock(Clock),
		.rst_n(rst_n),
		.frame_tick(frame_tick),
		.pos(player_pos),
		.gnt(player_gnt),
		.req(player_req),
		.wr(player_wr)
	);

	box_drawer #(
		.BOX_W(`RUNNER_OBST_W),
		.BOX_H(`RUNNER_OBST_H),
		.BOX_COLOR(`RUNNER_OBST_COLOR)
	) u_obst_draw (
		.Clock(Clock),
		.rst_n(rst_n),
		.frame_tick(frame_tick),
		.pos(obst_pos),
		.gnt(obst_gnt),
		.req(obst_req),
		.wr(obst_wr)
	);

	pixel_arbiter u_arb (
		.Clock(Clock),
		.rst_n(rst_n),
		.player_req(player_req),
		.obst_req(obst_req),
		.player_wr(player_wr),
		.obst_wr(obst_wr),
		.player_gnt(player_gnt),
		.obst_gnt(obst_gnt),
		.pixel(pixel)
	);

	score_keeper u_score (
		.Clock(Clock),
		.rst_n(rst_n),
		.player_pos(player_pos),
		.obst_pos(obst_pos),
		.score(score),
		.game_over(game_over),
		.respawn(respawn)
	);

endmodule

// ==== verification/runner_properties.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module runner_properties (
	input logic Clock,
	input logic rst_n,
	input runner_pkg::pixel_wr_t pixel,
	input logic player_gnt,
	input logic obst_gnt,
	input runner_pkg::score_t score,
	input logic game_over
);
	int unsigned failures = 0;

	write_on_screen: assert property (@(posedge Clock) disable iff (!rst_n)
		pixel.write |-> (pixel.x < `RUNNER_XSCREEN) && (pixel.y < `RUNNER_YSCREEN))
	else begin
		failures++;
		$error("Pixel write lies off the screen");
	end

	// Only one drawer may own the bus
	grants_exclusive: assert property (@(posedge Clock) disable iff (!rst_n)
		!(player_gnt && obst_gnt))
	else begin
		failures++;
		$error("Both grants are high");
	end

	game_over_sticky: assert property (@(posedge Clock) disable iff (!rst_n)
		game_over |=> game_over)
	else begin
		failures++;
		$error("game_over fell without reset");
	end

	score_steps_by_one: assert property (@(posedge Clock) disable iff (!rst_n)
		(score == $past(score)) || (score == runner_pkg::score_t'($past(score) + 1'b1)))
	else begin
		failures++;
		$error("score changed by more than one");
	end

endmodule

bind runner_top runner_properties u_props (
	.Clock(Clock),
	.rst_n(rst_n),
	.pixel(pixel),
	.player_gnt(player_gnt),
	.obst_gnt(obst_gnt),
	.score(score),
	.game_over(game_over)
);

// ==== verification/runner_tb.sv ====
`timescale 1ns/10ps
`include "runner_params.svh"

module runner_tb;
	localparam int FRAME_DIV = `RUNNER_FRAME_DIV;
	localparam int BIT_CLKS = `RUNNER_CLK_HZ / `RUNNER_BAUD;
	localparam int PLAYER_PIX = `RUNNER_PLAYER_W * `RUNNER_PLAYER_H;
	localparam int OBST_PIX = `RUNNER_OBST_W * `RUNNER_OBST_H;
	localparam int FRAME_WRITES = 2 * (PLAYER_PIX + OBST_PIX);
	// Obstacle rests on the ground row and stops where it first touches the player
	localparam int OBST_Y = `RUNNER_GROUND_Y + `RUNNER_PLAYER_H - `RUNNER_OBST_H;
	localparam int HIT_X = `RUNNER_PLAYER_X + `RUNNER_PLAYER_W;
	localparam int QUIET_CLKS = 16;
	localparam int OBSERVE_CLKS = 4 * FRAME_DIV;
	localparam int JUMP_TIMEOUT = 4 * FRAME_DIV;
	localparam int RESULT_TIMEOUT = 400 * FRAME_DIV;
	localparam int WRITE_TIMEOUT = 2 * FRAME_DIV;
	localparam int START_TIMEOUT = 1_000_000;
	localparam string STIM_FILE = "verification/runner_stim.txt";
	// ASCII "J"
	localparam runner_pkg::uart_byte_t JUMP_BYTE = 8'h4A;
	localparam runner_pkg::color_t PLAYER_COLOR = `RUNNER_PLAYER_COLOR;
	localparam runner_pkg::color_t OBST_COLOR = `RUNNER_OBST_COLOR;
	localparam runner_pkg::color_t BG_COLOR = `RUNNER_BG_COLOR;
	localparam runner_pkg::xcoord_t PLAYER_X = `RUNNER_PLAYER_X;
	localparam runner_pkg::ycoord_t GROUND_Y = `RUNNER_GROUND_Y;

	logic Clock;
	logic rst_n;
	logic uart_rx;
	runner_pkg::pixel_wr_t pixel;
	runner_pkg::score_t score;
	logic game_over;

	int unsigned cycle;
	int unsigned high_write_count;
	int unsigned mismatch_count;
	int unsigned failure_count;
	runner_pkg::score_t last_exp_score;

	runner_top DUT (
		.Clock(Clock),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.pixel(pixel),
		.score(score),
		.game_over(game_over)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Clocks since reset release, used for record start times
	always @(posedge Clock) begin
		if (!rst_n)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	// Bus monitor for colors, player columns and raised player rows
	always @(negedge Clock) begin
		if (rst_n && pixel.write === 1'b1) begin
			if (pixel.color != PLAYER_COLOR && pixel.color != OBST_COLOR &&
				pixel.color != BG_COLOR) begin
				failure_count++;
				$display("Pixel write with an unknown color %h at x=%h y=%h",
					pixel.color, pixel.x, pixel.y);
			end
			if (pixel.color == PLAYER_COLOR) begin
				if (pixel.x < PLAYER_X || pixel.x > PLAYER_X + 7) begin
					failure_count++;
					$display("Player pixel written outside its columns at x=%h", pixel.x);
				end
				if (pixel.y < GROUND_Y)
					high_write_count++;
			end
		end
	end

	task automatic check_score(input string name, input runner_pkg::score_t got,
		input runner_pkg::score_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_pixel(input string name, input runner_pkg::pixel_wr_t got,
		input runner_pkg::pixel_wr_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic runner_pkg::uart_byte_t filler_byte();
		runner_pkg::uart_byte_t b;
		b = runner_pkg::uart_byte_t'($urandom);
		if (b == JUMP_BYTE)
			b = b + 8'd1;
		return b;
	endfunction

	// Player box first, then the obstacle, each erased and redrawn row by row
	function automatic runner_pkg::pixel_wr_t frozen_write(input int idx);
		runner_pkg::pixel_wr_t p;
		int k;
		p.write = 1'b1;
		if (idx < 2 * PLAYER_PIX) begin
			k = idx % PLAYER_PIX;
			p.x = runner_pkg::xcoord_t'(`RUNNER_PLAYER_X + k % `RUNNER_PLAYER_W);
			p.y = runner_pkg::ycoord_t'(`RUNNER_GROUND_Y + k / `RUNNER_PLAYER_W);
			p.color = (idx < PLAYER_PIX) ? BG_COLOR : PLAYER_COLOR;
		end else begin
			k = (idx - 2 * PLAYER_PIX) % OBST_PIX;
			p.x = runner_pkg::xcoord_t'(HIT_X + k % `RUNNER_OBST_W);
			p.y = runner_pkg::ycoord_t'(OBST_Y + k / `RUNNER_OBST_W);
			p.color = (idx < 2 * PLAYER_PIX + OBST_PIX) ? BG_COLOR : OBST_COLOR;
		end
		return p;
	endfunction

	// 8N1 frame, LSB first
	task automatic send_byte(input runner_pkg::uart_byte_t data);
		logic [9:0] frame;
		int i;
		frame = {1'b1, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge Clock);
			uart_rx <= frame[i];
			repeat (BIT_CLKS - 1) @(posedge Clock);
		end
	endtask

	task automatic wait_until_cycle(input int unsigned at);
		int unsigned n;
		n = 0;
		while (cycle < at && n < START_TIMEOUT) begin
			@(posedge Clock);
			n++;
		end
		if (cycle < at) begin
			failure_count++;
			$display("Timed out waiting for clock %0d after reset", at);
		end
	endtask

	task automatic watch_no_jump(input int unsigned seen, input runner_pkg::uart_byte_t data);
		int n;
		for (n = 0; n < OBSERVE_CLKS; n++)
			@(negedge Clock);
		if (high_write_count != seen) begin
			failure_count++;
			$display("Player rose after byte %h, which is not a jump command", data);
		end
	endtask

	task automatic wait_for_jump(input int unsigned seen);
		int n;
		n = 0;
		while (high_write_count == seen && n < JUMP_TIMEOUT) begin
			@(negedge Clock);
			n++;
		end
		if (high_write_count == seen) begin
			failure_count++;
			$display("No raised player write after the jump command");
		end
	endtask

	task automatic wait_for_result(input runner_pkg::score_t exp_score, input logic exp_over);
		int n;
		n = 0;
		while (!(score === exp_score && game_over === exp_over) && n < RESULT_TIMEOUT) begin
			@(negedge Clock);
			n++;
		end
		if (!(score === exp_score && game_over === exp_over)) begin
			failure_count++;
			$display("Timed out waiting for score %h with game_over %h", exp_score, exp_over);
		end
	endtask

	task automatic next_write();
		int n;
		n = 0;
		@(negedge Clock);
		while (pixel.write !== 1'b1 && n < WRITE_TIMEOUT) begin
			@(negedge Clock);
			n++;
		end
		if (pixel.write !== 1'b1) begin
			failure_count++;
			$display("No pixel write within %0d clocks", WRITE_TIMEOUT);
		end
	endtask

	// A long gap without writes only falls between two frames
	task automatic wait_bus_quiet();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < QUIET_CLKS && n < WRITE_TIMEOUT) begin
			@(negedge Clock);
			quiet = (pixel.write === 1'b1) ? 0 : quiet + 1;
			n++;
		end
		if (quiet < QUIET_CLKS) begin
			failure_count++;
			$display("Pixel bus never went quiet between two frames");
		end
	endtask

	task automatic check_reset_quiet();
		int n;
		for (n = 0; n < FRAME_DIV / 2; n++) begin
			@(negedge Clock);
			check_flag("pixel.write", pixel.write, 1'b0);
			check_flag("game_over", game_over, 1'b0);
			check_score("score", score, '0);
		end
	endtask

	task automatic run_record(input int unsigned at, input int kind,
		input runner_pkg::uart_byte_t data, input runner_pkg::score_t exp_score,
		input logic exp_over);
		int unsigned seen;
		runner_pkg::uart_byte_t sent;
		wait_until_cycle(at);
		seen = high_write_count;
		if (kind == 2) begin
			sent = filler_byte();
			send_byte(sent);
			watch_no_jump(seen, sent);
		end else if (kind == 1) begin
			send_byte(data);
			if (data == JUMP_BYTE)
				wait_for_jump(seen);
		end
		wait_for_result(exp_score, exp_over);
		check_score("score", score, exp_score);
		check_flag("game_over", game_over, exp_over);
		last_exp_score = exp_score;
	endtask

	// Frozen positions repeat the same write sequence every frame
	task automatic check_frozen_frames();
		int n;
		if (game_over !== 1'b1) begin
			failure_count++;
			$display("Game over never reached, frozen redraw not checked");
		end else begin
			// Drawers sample one tick late, so skip the frame that still erases the last move
			for (n = 0; n < 2 * FRAME_DIV; n++)
				@(negedge Clock);
			wait_bus_quiet();
			for (n = 0; n < FRAME_WRITES; n++) begin
				next_write();
				check_pixel("pixel", pixel, frozen_write(n));
			end
			check_flag("game_over", game_over, 1'b1);
			check_score("score", score, last_exp_score);
		end
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		int unsigned at;
		int kind;
		runner_pkg::uart_byte_t data;
		runner_pkg::score_t exp_score;
		logic exp_over;
		int unsigned total;

		void'($urandom(32'hd880_3918));
		rst_n = 1'b0;
		uart_rx = 1'b1;
		repeat (2) @(posedge Clock);
		rst_n <= 1'b1;
		check_reset_quiet();

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			failure_count++;
			$display("Cannot open the stimulus file %s", STIM_FILE);
		end else begin
			while ($fgets(line, fd) > 0) begin
				fields = $sscanf(line, "%d %d %h %h %h", at, kind, data, exp_score, exp_over);
				if (line.substr(0, 0) != "#" && fields == 5)
					run_record(at, kind, data, exp_score, exp_over);
			end
			$fclose(fd);
		end
		check_frozen_frames();

		total = mismatch_count + failure_count + DUT.u_props.failures;
		$display("Mismatches: %0d, other errors: %0d, assertion failures: %0d",
			mismatch_count, failure_count, DUT.u_props.failures);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== runner_top.f ====
+incdir+verilog
verilog/runner_pkg.sv
verilog/uart_cmd_rx.sv
verilog/player_motion.sv
verilog/obstacle_motion.sv
verilog/box_drawer.sv
verilog/pixel_arbiter.sv
verilog/score_keeper.sv
verilog/runner_top.sv
verification/runner_properties.sv
verification/runner_tb.sv

// ==== verification/runner_stim.txt ====
# Columns: start clock after reset (decimal), kind, byte, expected score, expected game_over
# Kind 0 sends nothing, 1 sends the byte, 2 sends a random byte other than J; last three in hex
2000 2 00 0000 0
8000 2 00 0000 0
14000 2 00 0000 0
# Early jump well before the obstacle arrives
20000 1 4a 0000 0
60000 2 00 0000 0
66000 2 00 0000 0
# Jump that clears the obstacle near tick 250
255200 1 4a 0001 0
# No jump, the respawned obstacle ends the game
0 0 00 0001 1
